// ==== Bender.yml ====
package:
  name: demod_io

sources:
  - rtl/bus_pkg.sv
  - rtl/dac_pkg.sv
  - rtl/reg_bus_decode.sv
  - rtl/misc_regs.sv
  - rtl/dac_serial_ctrl.sv
  - rtl/dac_output.sv
  - rtl/demod_io_top.sv
  - target: test
    files:
      - bench/tb_demod_io.sv

// ==== bench/tb_demod_io.sv ====
// directed testbench for demod_io_top with an APB master and a DAC serial slave model
// every bus and serial wait gives up after TIMEOUT_CYCLES clock cycles
`timescale 1ns/100ps
`default_nettype none

module tb_demod_io;

  localparam int TIMEOUT_CYCLES = 200;

  logic                        ck933;
  logic                        rs;
  bus_pkg::apb_req_t           apb_req;
  bus_pkg::apb_rsp_t           apb_rsp;
  logic [dac_pkg::ADC_W-1:0]   adc_d;
  dac_pkg::dac_word_t          dac0_d;
  dac_pkg::dac_word_t          dac1_d;
  dac_pkg::dac_word_t          dac2_d;
  logic                        dac_rst;
  logic                        dac_sclk;
  logic [dac_pkg::NUM_DAC-1:0] dac_ncs;
  wire                         dac_sdio;
  logic [15:0]                 gpio;
  logic                        ncs_idle;

  int          errors;
  int          tests;
  logic [31:0] lcg_state;

  // serial slave model
  logic [15:0] slv_shift  = '0;
  int          slv_cnt    = 0;
  logic        slv_rd     = 1'b0;
  logic        slv_oe     = 1'b0;
  logic        slv_bit    = 1'b0;
  logic [7:0]  slv_preset = '0;
  logic [15:0] last_word  = '0;  // bits seen in the last finished transfer
  int          last_cnt   = 0;

  demod_io_top UUT (
    .ck933      (ck933),
    .rs         (rs),
    .apb_req_i  (apb_req),
    .apb_rsp_o  (apb_rsp),
    .adc_d_i    (adc_d),
    .dac0_d_o   (dac0_d),
    .dac1_d_o   (dac1_d),
    .dac2_d_o   (dac2_d),
    .dac_rst_o  (dac_rst),
    .dac_sclk_o (dac_sclk),
    .dac_ncs_o  (dac_ncs),
    .dac_sdio   (dac_sdio),
    .gpio_o     (gpio)
  );

  initial begin
    ck933 = 1'b0;
    forever #10 ck933 = ~ck933;
  end

  // ******************************
  // DAC serial slave
  assign ncs_idle = &dac_ncs;
  assign dac_sdio = slv_oe ? slv_bit : 1'bz;

  always @(posedge dac_sclk) begin
    if (!ncs_idle) begin
      slv_shift <= {slv_shift[14:0], dac_sdio};
      slv_cnt   <= slv_cnt + 1;
      if (slv_cnt == 0) slv_rd <= dac_sdio;  // first bit is the read flag
    end
  end

  // read byte goes out on falling edges after the instruction byte
  always @(negedge dac_sclk) begin
    if (!ncs_idle && slv_rd && slv_cnt >= 8 && slv_cnt < 16) begin
      slv_oe  <= 1'b1;
      slv_bit <= slv_preset[15-slv_cnt];
    end
  end

  always @(posedge ncs_idle) begin
    last_word <= slv_shift;
    last_cnt  <= slv_cnt;
    slv_oe    <= 1'b0;
  end

  always @(negedge ncs_idle) begin
    slv_cnt <= 0;
    slv_rd  <= 1'b0;
  end

  // ******************************
  // helpers
  function automatic logic [15:0] rand16();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  function automatic logic [11:0] reg_address(input bus_pkg::region_e r,
                                              input bus_pkg::reg_addr_e o);
    return {2'b00, r, o};
  endfunction

  function automatic logic [2:0] expected_ncs(input logic [1:0] sel);
    logic [1:0] idx;
    idx = (sel == 2'd3) ? 2'd2 : sel;
    return ~(3'b001 << idx);
  endfunction

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("CHECK FAILED %s: %s expected 0x%0h actual 0x%0h", test, what, exp, act);
    errors++;
  endtask

  task automatic finish_test(input string test, input int e0);
    tests++;
    if (errors == e0) $display("test %s: ok", test);
    else $display("test %s: %0d errors", test, errors - e0);
  endtask

  task automatic apb_transfer(input logic wr, input logic [11:0] addr, input logic [15:0] wdata,
                              output logic [15:0] rdata, output logic err, output int waits);
    int n;
    n = 0;
    @(posedge ck933);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge ck933);
    apb_req.penable <= 1'b1;
    @(negedge ck933);
    while (!apb_rsp.pready && n < TIMEOUT_CYCLES) begin
      n++;
      @(negedge ck933);
    end
    if (!apb_rsp.pready) begin
      $display("timeout: APB access to 0x%h never got pready", addr);
      errors++;
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    waits = n;
    @(posedge ck933);  // completing edge
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [15:0] data,
                           output logic err, output int waits);
    logic [15:0] unused;
    apb_transfer(1'b1, addr, data, unused, err, waits);
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [15:0] data, output logic err);
    int waits;
    apb_transfer(1'b0, addr, 16'h0000, data, err, waits);
  endtask

  task automatic count_reset_cycles(output int cycles);
    cycles = 0;
    @(negedge ck933);
    while (dac_rst && cycles < TIMEOUT_CYCLES) begin
      cycles++;
      @(negedge ck933);
    end
    if (dac_rst) begin
      $display("timeout: dac reset never went low");
      errors++;
    end
  endtask

  task automatic wait_transfer_end();
    int n;
    n = 0;
    @(negedge ck933);
    while (!ncs_idle && n < TIMEOUT_CYCLES) begin
      n++;
      @(negedge ck933);
    end
    if (!ncs_idle) begin
      $display("timeout: DAC serial transfer did not end");
      errors++;
    end
  endtask

  // ******************************
  // directed tests
  task automatic test_reset_state();
    int          e0;
    int          cycles;
    logic [15:0] rd;
    logic        err;
    e0 = errors;
    count_reset_cycles(cycles);
    if (cycles != 6) report_mismatch("reset_state", "rst cycles", 6, cycles);
    apb_read(reg_address(bus_pkg::REGION_MISC, bus_pkg::REG_VERSION), rd, err);
    if (rd !== 16'h003f) report_mismatch("reset_state", "version", 16'h003f, rd);
    if (err !== 1'b0) report_mismatch("reset_state", "pslverr", 0, err);
    @(negedge ck933);
    if (dac0_d !== 14'h2000) report_mismatch("reset_state", "dac0", 14'h2000, dac0_d);
    if (dac1_d !== 14'h2000) report_mismatch("reset_state", "dac1", 14'h2000, dac1_d);
    if (dac2_d !== 14'h2000) report_mismatch("reset_state", "dac2", 14'h2000, dac2_d);
    if (dac_ncs !== 3'b111) report_mismatch("reset_state", "ncs", 3'b111, dac_ncs);
    if (dac_sclk !== 1'b0) report_mismatch("reset_state", "sclk", 0, dac_sclk);
    finish_test("reset_state", e0);
  endtask

  task automatic test_sample_path();
    int          e0;
    int          waits;
    logic        err;
    logic [15:0] d;
    logic [15:0] rd;
    e0 = errors;
    repeat (4) begin
      d = rand16();
      apb_write(reg_address(bus_pkg::REGION_DAC_OUT, bus_pkg::REG_CH1_SAMPLE), d, err, waits);
      @(posedge ck933);
      @(negedge ck933);
      if (dac1_d !== {~d[15], d[14:2]})
        report_mismatch("sample_path", "dac1", {~d[15], d[14:2]}, dac1_d);
      apb_read(reg_address(bus_pkg::REGION_DAC_OUT, bus_pkg::REG_CH1_SAMPLE), rd, err);
      if (rd !== d) report_mismatch("sample_path", "ch1 read", d, rd);
      d = rand16();
      apb_write(reg_address(bus_pkg::REGION_DAC_OUT, bus_pkg::REG_CH2_SAMPLE), d, err, waits);
      @(posedge ck933);
      @(negedge ck933);
      if (dac2_d !== {~d[15], d[14:2]})
        report_mismatch("sample_path", "dac2", {~d[15], d[14:2]}, dac2_d);
      apb_read(reg_address(bus_pkg::REGION_DAC_OUT, bus_pkg::REG_CH2_SAMPLE), rd, err);
      if (rd !== d) report_mismatch("sample_path", "ch2 read", d, rd);
    end
    d = rand16();
    apb_write(reg_address(bus_pkg::REGION_MISC, bus_pkg::REG_GPIO), d, err, waits);
    apb_read(reg_address(bus_pkg::REGION_MISC, bus_pkg::REG_GPIO), rd, err);
    if (rd !== d) report_mismatch("sample_path", "gpio read", d, rd);
    if (gpio !== d) report_mismatch("sample_path", "gpio pins", d, gpio);
    finish_test("sample_path", e0);
  endtask

  task automatic test_adc_loopback();
    int          e0;
    logic [15:0] r;
    logic [13:0] v;
    e0 = errors;
    repeat (6) begin
      r = rand16();
      v = r[13:0];
      @(posedge ck933);
      adc_d <= v;
      repeat (2) @(posedge ck933);  // reclock then pin register
      @(negedge ck933);
      if (dac0_d !== {~v[13], v[12:0]})
        report_mismatch("adc_loopback", "dac0", {~v[13], v[12:0]}, dac0_d);
    end
    finish_test("adc_loopback", e0);
  endtask

  task automatic test_serial_write();
    int          e0;
    int          waits;
    logic        err;
    logic [15:0] ctrl_a;
    logic [15:0] ctrl_b;
    e0     = errors;
    ctrl_a = rand16() & 16'h7fff;  // rd clear
    ctrl_b = rand16() & 16'h7fff;
    apb_write(reg_address(bus_pkg::REGION_DAC_SPI, bus_pkg::REG_SPI_CTRL), ctrl_a, err, waits);
    @(negedge ck933);
    if (dac_ncs !== expected_ncs(ctrl_a[14:13]))
      report_mismatch("serial_write", "ncs", expected_ncs(ctrl_a[14:13]), dac_ncs);
    // second write lands while the first transfer runs
    apb_write(reg_address(bus_pkg::REGION_DAC_SPI, bus_pkg::REG_SPI_CTRL), ctrl_b, err, waits);
    if (waits == 0) begin
      $display("serial_write: control write during a busy transfer got no wait states");
      errors++;
    end
    if (last_cnt != 16) report_mismatch("serial_write", "bit count", 16, last_cnt);
    if (last_word !== {ctrl_a[15], 2'b00, ctrl_a[12:0]})
      report_mismatch("serial_write", "first word", {ctrl_a[15], 2'b00, ctrl_a[12:0]}, last_word);
    @(negedge ck933);
    if (dac_ncs !== expected_ncs(ctrl_b[14:13]))
      report_mismatch("serial_write", "ncs second", expected_ncs(ctrl_b[14:13]), dac_ncs);
    wait_transfer_end();
    if (last_cnt != 16) report_mismatch("serial_write", "bit count second", 16, last_cnt);
    if (last_word !== {ctrl_b[15], 2'b00, ctrl_b[12:0]})
      report_mismatch("serial_write", "second word", {ctrl_b[15], 2'b00, ctrl_b[12:0]}, last_word);
    finish_test("serial_write", e0);
  endtask

  task automatic test_serial_read();
    int          e0;
    int          waits;
    logic        err;
    logic [15:0] r;
    logic [15:0] ctrl;
    logic [15:0] rd;
    e0         = errors;
    r          = rand16();
    slv_preset = r[7:0];
    r          = rand16();
    ctrl       = {1'b1, r[14:8], 8'h00};
    apb_write(reg_address(bus_pkg::REGION_DAC_SPI, bus_pkg::REG_SPI_CTRL), ctrl, err, waits);
    wait_transfer_end();
    if (last_word !== {1'b1, 2'b00, ctrl[12:8], slv_preset})
      report_mismatch("serial_read", "line bits", {1'b1, 2'b00, ctrl[12:8], slv_preset}, last_word);
    apb_read(reg_address(bus_pkg::REGION_DAC_SPI, bus_pkg::REG_SPI_STATUS), rd, err);
    if (rd[15:8] !== slv_preset) report_mismatch("serial_read", "read byte", slv_preset, rd[15:8]);
    if (rd[0] !== 1'b0) report_mismatch("serial_read", "busy", 0, rd[0]);
    finish_test("serial_read", e0);
  endtask

  task automatic test_soft_reset();
    int          e0;
    int          waits;
    int          cycles;
    logic        err;
    logic [15:0] rd;
    e0 = errors;
    apb_write(reg_address(bus_pkg::REGION_MISC, bus_pkg::REG_GPIO), rand16() | 16'h1, err, waits);
    apb_write(reg_address(bus_pkg::REGION_DAC_OUT, bus_pkg::REG_CH1_SAMPLE), 16'h5a5c, err, waits);
    apb_write(reg_address(bus_pkg::REGION_DAC_OUT, bus_pkg::REG_CH2_SAMPLE), 16'h8124, err, waits);
    apb_write(reg_address(bus_pkg::REGION_MISC, bus_pkg::REG_RESET), 16'h0001, err, waits);
    count_reset_cycles(cycles);
    if (cycles != 6) report_mismatch("soft_reset", "rst cycles", 6, cycles);
    apb_read(reg_address(bus_pkg::REGION_MISC, bus_pkg::REG_GPIO), rd, err);
    if (rd !== 16'h0) report_mismatch("soft_reset", "gpio", 0, rd);
    apb_read(reg_address(bus_pkg::REGION_DAC_OUT, bus_pkg::REG_CH1_SAMPLE), rd, err);
    if (rd !== 16'h0) report_mismatch("soft_reset", "ch1", 0, rd);
    apb_read(reg_address(bus_pkg::REGION_DAC_OUT, bus_pkg::REG_CH2_SAMPLE), rd, err);
    if (rd !== 16'h0) report_mismatch("soft_reset", "ch2", 0, rd);
    @(negedge ck933);
    if (dac1_d !== 14'h2000) report_mismatch("soft_reset", "dac1", 14'h2000, dac1_d);
    if (dac2_d !== 14'h2000) report_mismatch("soft_reset", "dac2", 14'h2000, dac2_d);
    apb_read(12'hf00, rd, err);  // unmapped region
    if (err !== 1'b1) report_mismatch("soft_reset", "pslverr", 1, err);
    if (rd !== 16'h0) report_mismatch("soft_reset", "unmapped prdata", 0, rd);
    finish_test("soft_reset", e0);
  endtask

  // ******************************
  // main sequence
  initial begin
    rs        = 1'b1;
    apb_req   = '0;
    adc_d     = '0;
    lcg_state = 32'h5216;
    errors    = 0;
    tests     = 0;
    repeat (16) @(posedge ck933);
    rs <= 1'b0;
    test_reset_state();
    test_sample_path();
    test_adc_loopback();
    test_serial_write();
    test_serial_read();
    test_soft_reset();
    $display("tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/bus_pkg.sv ====
// register bus types and address map for the DAC/ADC top level
// registers are 16 bit on even byte offsets; paddr[11:8] picks the region
`default_nettype none

package bus_pkg;

  localparam int ADDR_W = 12;
  localparam int DATA_W = 16;

  localparam logic [DATA_W-1:0] VERSION_NUMBER = 16'h003f;

  localparam int SOFT_RST_CYCLES = 6;  // stretched reset length
  localparam int RST_CNT_W = $clog2(SOFT_RST_CYCLES);

  typedef logic [RST_CNT_W-1:0] rst_cnt_t;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;  // byte address
    logic [DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  typedef enum logic [1:0] {
    REGION_MISC    = 2'd0,
    REGION_DAC_SPI = 2'd1,
    REGION_DAC_OUT = 2'd2,
    REGION_NONE    = 2'd3   // paddr[11:8] of 3 and up
  } region_e;

  // offsets repeat between regions, so the names below alias these codes
  typedef enum logic [7:0] {
    REG_OFS_00 = 8'h00,
    REG_OFS_02 = 8'h02,
    REG_OFS_04 = 8'h04
  } reg_addr_e;

  localparam reg_addr_e REG_VERSION    = REG_OFS_00;  // misc region
  localparam reg_addr_e REG_RESET      = REG_OFS_02;
  localparam reg_addr_e REG_GPIO       = REG_OFS_04;
  localparam reg_addr_e REG_SPI_CTRL   = REG_OFS_00;  // DAC serial region
  localparam reg_addr_e REG_SPI_STATUS = REG_OFS_02;
  localparam reg_addr_e REG_CH1_SAMPLE = REG_OFS_00;  // DAC output region
  localparam reg_addr_e REG_CH2_SAMPLE = REG_OFS_02;

  // write strobe is high only in the completing access cycle
  typedef struct packed {
    logic              wr;
    reg_addr_e         addr;
    logic [DATA_W-1:0] data;
  } bus_wr_t;

endpackage

`default_nettype wire

// ==== rtl/dac_output.sv ====
// DAC data path: ADC reclock, two bus-written sample registers, pin registers
// 18-bit two's complement samples go out as 14-bit offset binary words
`timescale 1ns/100ps
`default_nettype none

module dac_output (
  input  wire                         ck933,
  input  wire                         core_rst_i,
  input  wire bus_pkg::bus_wr_t       wr_i,
  input  wire                         sel_i,
  output logic [bus_pkg::DATA_W-1:0]  rdata_o,
  input  wire [dac_pkg::ADC_W-1:0]    adc_d_i,
  output dac_pkg::dac_word_t          dac0_d_o,
  output dac_pkg::dac_word_t          dac1_d_o,
  output dac_pkg::dac_word_t          dac2_d_o
);

  logic [dac_pkg::ADC_W-1:0]    adc_q;
  logic [bus_pkg::DATA_W-1:0]   ch1_q;
  logic [bus_pkg::DATA_W-1:0]   ch2_q;
  logic [dac_pkg::SAMPLE_W-1:0] sample [dac_pkg::NUM_DAC];
  dac_pkg::dac_word_t           dac_q [dac_pkg::NUM_DAC];

  // top 14 bits with the sign bit flipped
  function automatic dac_pkg::dac_word_t to_offset_bin(input logic [dac_pkg::SAMPLE_W-1:0] s);
    return {~s[dac_pkg::SAMPLE_W-1], s[dac_pkg::SAMPLE_W-2 -: dac_pkg::DAC_W-1]};
  endfunction

  // ******************************
  // ADC reclock and sample registers
  always_ff @(posedge ck933 or posedge core_rst_i) begin
    if (core_rst_i) begin
      adc_q <= '0;
      ch1_q <= '0;
      ch2_q <= '0;
    end else begin
      adc_q <= adc_d_i;
      if (wr_i.wr && sel_i) begin
        case (wr_i.addr)
          bus_pkg::REG_CH1_SAMPLE: ch1_q <= wr_i.data;
          bus_pkg::REG_CH2_SAMPLE: ch2_q <= wr_i.data;
          default: ;
        endcase
      end
    end
  end

  assign sample[0] = {adc_q, {(dac_pkg::SAMPLE_W - dac_pkg::ADC_W){1'b0}}};  // 4 zero lsbs
  assign sample[1] = {ch1_q, {(dac_pkg::SAMPLE_W - bus_pkg::DATA_W){1'b0}}};
  assign sample[2] = {ch2_q, {(dac_pkg::SAMPLE_W - bus_pkg::DATA_W){1'b0}}};

  // pin registers, mid scale out of reset
  always_ff @(posedge ck933 or posedge core_rst_i) begin
    if (core_rst_i) begin
      for (int i = 0; i < dac_pkg::NUM_DAC; i++) begin
        dac_q[i] <= dac_pkg::DAC_ZERO;
      end
    end else begin
      for (int i = 0; i < dac_pkg::NUM_DAC; i++) begin
        dac_q[i] <= to_offset_bin(sample[i]);
      end
    end
  end

  assign dac0_d_o = dac_q[0];
  assign dac1_d_o = dac_q[1];
  assign dac2_d_o = dac_q[2];

  always_comb begin
    case (wr_i.addr)
      bus_pkg::REG_CH1_SAMPLE: rdata_o = ch1_q;
      bus_pkg::REG_CH2_SAMPLE: rdata_o = ch2_q;
      default:                 rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/dac_pkg.sv ====
// DAC sample formats and serial control port definitions
// samples are 18 bit two's complement, DAC words 14 bit offset binary
`default_nettype none

package dac_pkg;

  localparam int SAMPLE_W = 18;
  localparam int DAC_W    = 14;
  localparam int ADC_W    = 14;
  localparam int NUM_DAC  = 3;

  localparam int SCLK_DIV = 4;   // ck933 cycles per sclk period
  localparam int SPI_BITS = 16;  // instruction byte + data byte

  localparam int DIV_W = $clog2(SCLK_DIV);
  localparam int BIT_W = $clog2(SPI_BITS);

  typedef logic [DIV_W-1:0] sclk_div_t;
  typedef logic [BIT_W-1:0] spi_bit_t;

  // view of the serial control register
  typedef struct packed {
    logic       rd;       // 1 = read from the DAC
    logic [1:0] dac_sel;  // 3 selects DAC2 as well
    logic [4:0] addr;
    logic [7:0] data;
  } spi_ctrl_t;

  typedef enum logic [1:0] {
    SPI_IDLE  = 2'd0,
    SPI_INSTR = 2'd1,
    SPI_DATA  = 2'd2
  } spi_state_e;

  typedef logic [DAC_W-1:0] dac_word_t;

  localparam dac_word_t DAC_ZERO = {1'b1, {(DAC_W-1){1'b0}}};  // mid scale

endpackage

`default_nettype wire

// ==== rtl/dac_serial_ctrl.sv ====
// DAC serial control port, one 16-bit transfer shared by three chip selects
// sdio changes on sclk falling edges; a control write is taken only when idle
`timescale 1ns/100ps
`default_nettype none

module dac_serial_ctrl (
  input  wire                        ck933,
  input  wire                        core_rst_i,
  input  wire bus_pkg::bus_wr_t      wr_i,
  input  wire                        sel_i,
  output logic [bus_pkg::DATA_W-1:0] rdata_o,
  output logic                       busy_o,
  output logic                       sclk_o,
  output logic [dac_pkg::NUM_DAC-1:0] ncs_o,
  output logic                       sdio_o,
  output logic                       sdio_oe_o,
  input  wire                        sdio_i
);

  dac_pkg::spi_state_e           state_q;
  dac_pkg::spi_ctrl_t            ctrl_q;
  dac_pkg::spi_ctrl_t            ctrl_wr;
  dac_pkg::sclk_div_t            div_q;
  dac_pkg::spi_bit_t             bit_q;
  logic                          start_q;  // one cycle of ncs low before sclk runs
  logic [dac_pkg::SPI_BITS-1:0]  shift_q;
  logic [7:0]                    rd_byte_q;
  logic [1:0]                    dac_idx;
  logic                          start_wr;
  logic                          running;
  logic                          rise_edge;
  logic                          bit_end;

  assign ctrl_wr   = dac_pkg::spi_ctrl_t'(wr_i.data);
  assign dac_idx   = (ctrl_wr.dac_sel == 2'd3) ? 2'd2 : ctrl_wr.dac_sel;
  assign busy_o    = (state_q != dac_pkg::SPI_IDLE);
  assign start_wr  = wr_i.wr && sel_i && (wr_i.addr == bus_pkg::REG_SPI_CTRL) && !busy_o;
  assign running   = busy_o && !start_q;
  assign rise_edge = running && (div_q == dac_pkg::sclk_div_t'(dac_pkg::SCLK_DIV / 2 - 1));
  assign bit_end   = running && (div_q == dac_pkg::sclk_div_t'(dac_pkg::SCLK_DIV - 1));

  // ******************************
  // transfer FSM
  always_ff @(posedge ck933 or posedge core_rst_i) begin
    if (core_rst_i) begin
      state_q   <= dac_pkg::SPI_IDLE;
      ctrl_q    <= '0;
      div_q     <= '0;
      bit_q     <= '0;
      start_q   <= 1'b0;
      rd_byte_q <= '0;
      sclk_o    <= 1'b0;
      ncs_o     <= '1;
      sdio_oe_o <= 1'b0;
    end else if (start_wr) begin
      state_q        <= dac_pkg::SPI_INSTR;
      ctrl_q         <= ctrl_wr;
      div_q          <= '0;
      bit_q          <= dac_pkg::spi_bit_t'(dac_pkg::SPI_BITS - 1);
      start_q        <= 1'b1;
      ncs_o          <= '1;
      ncs_o[dac_idx] <= 1'b0;  // only the selected DAC
      sdio_oe_o      <= 1'b1;
    end else if (start_q) begin
      start_q <= 1'b0;
    end else if (running) begin
      div_q <= div_q + 1'b1;
      if (rise_edge) begin
        sclk_o <= 1'b1;
        if ((state_q == dac_pkg::SPI_DATA) && ctrl_q.rd) begin
          rd_byte_q <= {rd_byte_q[6:0], sdio_i};  // DAC drives msb first
        end
      end
      if (bit_end) begin
        sclk_o <= 1'b0;
        if (bit_q == '0) begin
          state_q   <= dac_pkg::SPI_IDLE;
          ncs_o     <= '1;
          sdio_oe_o <= 1'b0;
        end else begin
          bit_q <= bit_q - 1'b1;
          if (bit_q == dac_pkg::spi_bit_t'(dac_pkg::SPI_BITS / 2)) begin
            state_q <= dac_pkg::SPI_DATA;
            if (ctrl_q.rd) begin
              sdio_oe_o <= 1'b0;  // release sdio for the read byte
            end
          end
        end
      end
    end
  end

  // instruction byte is rd, two zeros, 5-bit address
  always_ff @(posedge ck933) begin
    if (start_wr) begin
      shift_q <= {ctrl_wr.rd, 2'b00, ctrl_wr.addr, ctrl_wr.data};
    end else if (bit_end) begin
      shift_q <= {shift_q[dac_pkg::SPI_BITS-2:0], 1'b0};
    end
  end

  assign sdio_o = shift_q[dac_pkg::SPI_BITS-1];

  always_comb begin
    case (wr_i.addr)
      bus_pkg::REG_SPI_CTRL:   rdata_o = ctrl_q;
      bus_pkg::REG_SPI_STATUS: rdata_o = {rd_byte_q, 7'b0, busy_o};
      default:                 rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/demod_io_top.sv ====
// register bus and DAC pin side of the demodulator top level
// DAC clocks are wired on the board; sdio is the only bidirectional pin
`timescale 1ns/100ps
`default_nettype none

module demod_io_top (
  input  wire                          ck933,
  input  wire                          rs,
  input  wire bus_pkg::apb_req_t       apb_req_i,
  output bus_pkg::apb_rsp_t            apb_rsp_o,
  input  wire [dac_pkg::ADC_W-1:0]     adc_d_i,
  output dac_pkg::dac_word_t           dac0_d_o,
  output dac_pkg::dac_word_t           dac1_d_o,
  output dac_pkg::dac_word_t           dac2_d_o,
  output logic                         dac_rst_o,
  output logic                         dac_sclk_o,
  output logic [dac_pkg::NUM_DAC-1:0]  dac_ncs_o,
  inout  wire                          dac_sdio,
  output logic [bus_pkg::DATA_W-1:0]   gpio_o
);

  bus_pkg::bus_wr_t           bus_wr;
  logic                       misc_sel;
  logic                       spi_sel;
  logic                       dac_out_sel;
  logic [bus_pkg::DATA_W-1:0] misc_rdata;
  logic [bus_pkg::DATA_W-1:0] spi_rdata;
  logic [bus_pkg::DATA_W-1:0] dac_out_rdata;
  logic                       spi_busy;
  logic                       core_rst;
  logic                       sdio_out;
  logic                       sdio_oe;

  // ******************************
  // bus decode
  reg_bus_decode u_decode (
    .ck933           (ck933),
    .rs              (rs),
    .apb_req_i       (apb_req_i),
    .apb_rsp_o       (apb_rsp_o),
    .spi_busy_i      (spi_busy),
    .wr_o            (bus_wr),
    .misc_sel_o      (misc_sel),
    .spi_sel_o       (spi_sel),
    .dac_out_sel_o   (dac_out_sel),
    .misc_rdata_i    (misc_rdata),
    .spi_rdata_i     (spi_rdata),
    .dac_out_rdata_i (dac_out_rdata)
  );

  misc_regs u_misc (
    .ck933      (ck933),
    .rs         (rs),
    .wr_i       (bus_wr),
    .sel_i      (misc_sel),
    .rdata_o    (misc_rdata),
    .core_rst_o (core_rst),
    .dac_rst_o  (dac_rst_o),
    .gpio_o     (gpio_o)
  );

  // ******************************
  // DAC serial port and data
  dac_serial_ctrl u_spi (
    .ck933      (ck933),
    .core_rst_i (core_rst),
    .wr_i       (bus_wr),
    .sel_i      (spi_sel),
    .rdata_o    (spi_rdata),
    .busy_o     (spi_busy),
    .sclk_o     (dac_sclk_o),  // one sclk for all three DACs
    .ncs_o      (dac_ncs_o),
    .sdio_o     (sdio_out),
    .sdio_oe_o  (sdio_oe),
    .sdio_i     (dac_sdio)
  );

  assign dac_sdio = sdio_oe ? sdio_out : 1'bz;

  dac_output u_dac_out (
    .ck933      (ck933),
    .core_rst_i (core_rst),
    .wr_i       (bus_wr),
    .sel_i      (dac_out_sel),
    .rdata_o    (dac_out_rdata),
    .adc_d_i    (adc_d_i),
    .dac0_d_o   (dac0_d_o),
    .dac1_d_o   (dac1_d_o),
    .dac2_d_o   (dac2_d_o)
  );

endmodule

`default_nettype wire

// ==== rtl/misc_regs.sv ====
// version, soft reset and GPIO registers
// core reset and dac reset stay high SOFT_RST_CYCLES after rs or a reset write
`timescale 1ns/100ps
`default_nettype none

module misc_regs (
  input  wire                       ck933,
  input  wire                       rs,
  input  wire bus_pkg::bus_wr_t     wr_i,
  input  wire                       sel_i,
  output logic [bus_pkg::DATA_W-1:0] rdata_o,
  output logic                      core_rst_o,
  output logic                      dac_rst_o,
  output logic [bus_pkg::DATA_W-1:0] gpio_o
);

  bus_pkg::rst_cnt_t rst_cnt_q;
  logic              core_rst_q;
  logic              soft_rst_wr;
  logic              gpio_wr;

  assign soft_rst_wr = wr_i.wr && sel_i && (wr_i.addr == bus_pkg::REG_RESET);
  assign gpio_wr     = wr_i.wr && sel_i && (wr_i.addr == bus_pkg::REG_GPIO);

  // ******************************
  // reset stretcher
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      rst_cnt_q  <= bus_pkg::rst_cnt_t'(bus_pkg::SOFT_RST_CYCLES - 1);
      core_rst_q <= 1'b1;
    end else if (soft_rst_wr) begin
      rst_cnt_q  <= bus_pkg::rst_cnt_t'(bus_pkg::SOFT_RST_CYCLES - 1);
      core_rst_q <= 1'b1;
    end else if (rst_cnt_q != '0) begin
      rst_cnt_q  <= rst_cnt_q - 1'b1;  // hold for the remaining cycles
      core_rst_q <= 1'b1;
    end else begin
      core_rst_q <= 1'b0;
    end
  end

  assign core_rst_o = core_rst_q;
  assign dac_rst_o  = core_rst_q;  // DAC reset pin tracks the core reset

  // GPIO is cleared by the stretched reset too
  always_ff @(posedge ck933 or posedge core_rst_q) begin
    if (core_rst_q) begin
      gpio_o <= '0;
    end else if (gpio_wr) begin
      gpio_o <= wr_i.data;
    end
  end

  always_comb begin
    case (wr_i.addr)
      bus_pkg::REG_VERSION: rdata_o = bus_pkg::VERSION_NUMBER;
      bus_pkg::REG_GPIO:    rdata_o = gpio_o;  // reads back the pin value
      default:              rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/reg_bus_decode.sv ====
// APB slave front end: region decode, wait states and read data mux
// only a control write to a busy serial port is held off
`timescale 1ns/100ps
`default_nettype none

module reg_bus_decode (
  input  wire                      ck933,
  input  wire                      rs,
  input  wire bus_pkg::apb_req_t   apb_req_i,
  output bus_pkg::apb_rsp_t        apb_rsp_o,
  input  wire                      spi_busy_i,
  output bus_pkg::bus_wr_t         wr_o,
  output logic                     misc_sel_o,
  output logic                     spi_sel_o,
  output logic                     dac_out_sel_o,
  input  wire [bus_pkg::DATA_W-1:0] misc_rdata_i,
  input  wire [bus_pkg::DATA_W-1:0] spi_rdata_i,
  input  wire [bus_pkg::DATA_W-1:0] dac_out_rdata_i
);

  bus_pkg::region_e region;
  logic             access;
  logic             ready;
  logic             setup_q;
  logic             complete;
  logic             spi_ctrl_wr;

  // region from the upper address nibble
  always_comb begin
    case (apb_req_i.paddr[11:8])
      4'h0:    region = bus_pkg::REGION_MISC;
      4'h1:    region = bus_pkg::REGION_DAC_SPI;
      4'h2:    region = bus_pkg::REGION_DAC_OUT;
      default: region = bus_pkg::REGION_NONE;
    endcase
  end

  assign access      = apb_req_i.psel && apb_req_i.penable;
  assign spi_ctrl_wr = (region == bus_pkg::REGION_DAC_SPI) && apb_req_i.pwrite &&
                       (apb_req_i.paddr[7:0] == bus_pkg::REG_SPI_CTRL);
  assign ready       = !(access && spi_ctrl_wr && spi_busy_i);  // the one wait state source
  assign complete    = access && ready && setup_q;

  // remembers the setup cycle until the transfer completes
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      setup_q <= 1'b0;
    end else if (apb_req_i.psel && !apb_req_i.penable) begin
      setup_q <= 1'b1;
    end else if (complete) begin
      setup_q <= 1'b0;
    end
  end

  assign wr_o.wr   = complete && apb_req_i.pwrite && (region != bus_pkg::REGION_NONE);
  assign wr_o.addr = bus_pkg::reg_addr_e'(apb_req_i.paddr[7:0]);
  assign wr_o.data = apb_req_i.pwdata;

  assign misc_sel_o    = (region == bus_pkg::REGION_MISC);
  assign spi_sel_o     = (region == bus_pkg::REGION_DAC_SPI);
  assign dac_out_sel_o = (region == bus_pkg::REGION_DAC_OUT);

  // ******************************
  // read data and response
  always_comb begin
    apb_rsp_o.pready  = ready;
    apb_rsp_o.pslverr = access && (region == bus_pkg::REGION_NONE);
    case (region)
      bus_pkg::REGION_MISC:    apb_rsp_o.prdata = misc_rdata_i;
      bus_pkg::REGION_DAC_SPI: apb_rsp_o.prdata = spi_rdata_i;
      bus_pkg::REGION_DAC_OUT: apb_rsp_o.prdata = dac_out_rdata_i;
      default:                 apb_rsp_o.prdata = '0;  // unmapped
    endcase
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/bus_pkg.sv
rtl/dac_pkg.sv
rtl/reg_bus_decode.sv
rtl/misc_regs.sv
rtl/dac_serial_ctrl.sv
rtl/dac_output.sv
rtl/demod_io_top.sv
bench/tb_demod_io.sv
